// File: Makefile
TOP = armControllerTb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): armController.f hdl/*.sv hdl/*.svh sim/*.sv
	verilator --binary --timing --assert -f armController.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f armController.f --top-module armController

clean:
	rm -rf obj_dir $(LOG)

// File: armController.f
+incdir+hdl
hdl/armCtrlPkg.sv
hdl/instrDecoder.sv
hdl/memAccessDecoder.sv
hdl/condUnit.sv
hdl/ctrlPipeline.sv
hdl/armController.sv
sim/clkGen.sv
sim/armControllerTb.sv

// File: hdl/armController.sv
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module armController (
  input  logic                clk,
  input  logic                rstN,
  input  logic                stall,      // Freezes every stage and the flags
  input  logic                flushE,     // Bubble into Execute
  input  logic [`INSTR_W-1:0] instrD,
  input  armCtrlPkg::flagsT   aluFlagsE,
  input  logic [1:0]          aluAddrE,
  output armCtrlPkg::exCtrlT  exCtrlE,
  output armCtrlPkg::memCtrlT memCtrlM,
  output armCtrlPkg::wbCtrlT  wbCtrlW,
  output armCtrlPkg::flagsT   flags
);

  armCtrlPkg::decodeCtrlT dec;          // Class and ALU side
  armCtrlPkg::memDecodeT  mem;          // Load/store side

  instrDecoder i_instrDecoder (
    .instrD (instrD),
    .dec    (dec)
  );

  memAccessDecoder i_memAccessDecoder (
    .instrD (instrD),
    .mem    (mem)
  );

  ctrlPipeline i_ctrlPipeline (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .flushE    (flushE),
    .instrD    (instrD),
    .dec       (dec),
    .mem       (mem),
    .aluFlagsE (aluFlagsE),
    .aluAddrE  (aluAddrE),
    .exCtrlE   (exCtrlE),
    .memCtrlM  (memCtrlM),
    .wbCtrlW   (wbCtrlW),
    .flags     (flags)
  );

endmodule

// File: hdl/armCtrlPkg.sv
`include "armCtrl_params.svh"

package armCtrlPkg;

  // ========================================
  // Encodings
  // ========================================

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,   // Z and C tests
    condMi, condPl, condVs, condVc,   // N and V tests
    condHi, condLs, condGe, condLt,   // Unsigned and signed compares
    condGt, condLe, condAl, condNv
  } condT;

  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb,
    opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn,       // Compare group, no register write
    opOrr, opMov, opBic, opMvn
  } aluOpT;

  // Zero is the no-op so a cleared register is a bubble
  typedef enum logic [2:0] {
    nop, dpImm, dpReg, mult, ldrStr, ldrStrHalf, branch
  } instrClassT;

  typedef enum logic [1:0] {
    sizeWord, sizeHalf, sizeByte
  } accessSizeT;

  // ========================================
  // Control records
  // ========================================

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef struct packed {
    instrClassT instrClass;
    aluOpT      aluOp;
    logic       aluSrc;          // Immediate operand B
    logic       regWrite;
    logic [1:0] flagWrite;       // [1] NZ, [0] CV
    logic       branch;
    logic       pcWrite;
  } decodeCtrlT;

  typedef struct packed {
    logic       memAccess;
    logic       store;
    accessSizeT size;
    logic [1:0] signedLoad;      // [1] signed byte, [0] signed halfword
  } memDecodeT;

  typedef struct packed {
    aluOpT aluControl;
    logic  aluSrc;
    logic  branchTaken;
  } exCtrlT;

  typedef struct packed {
    logic               memWrite;
    logic               memtoReg;
    logic [`MASK_W-1:0] byteMask;
    accessSizeT         size;
    logic [1:0]         signedLoad;
  } memCtrlT;

  typedef struct packed {
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;
    accessSizeT size;
    logic [1:0] signedLoad;
  } wbCtrlT;

  // ========================================
  // Transfer signatures
  // ========================================

  // LDR/STR word and byte
  // Register offset with bit 4 set is the undefined space
  function automatic logic isWordXfer(logic [`INSTR_W-1:0] instr);
    return (instr[27:26] == 2'b01) && !(instr[`I_BIT] && instr[4]);
  endfunction

  // LDRH/STRH/LDRSB/LDRSH
  // SH of 00 is multiply or swap, signed stores are not supported
  function automatic logic isHalfXfer(logic [`INSTR_W-1:0] instr);
    logic [1:0] sh;
    sh = instr[6:5];
    return (instr[27:25] == 3'b000) && instr[7] && instr[4] &&
           ((sh == 2'b01) || (instr[`L_BIT] && (sh != 2'b00)));
  endfunction

endpackage

// File: hdl/armCtrl_params.svh
`ifndef ARMCTRL_PARAMS_SVH
`define ARMCTRL_PARAMS_SVH

// Instruction word
`define INSTR_W     32

// Condition field
`define COND_MSB    31
`define COND_LSB    28

// Data processing opcode
`define OPC_MSB     24
`define OPC_LSB     21

// Destination register
`define RD_MSB      15
`define RD_LSB      12

// Single control bits
`define I_BIT       25  // Immediate operand or register offset
`define U_BIT       23  // Offset added to base
`define B_BIT       22  // Byte transfer
`define HIMM_BIT    22  // Immediate offset in halfword transfers
`define S_BIT       20  // Set condition flags
`define L_BIT       20  // Load, shares the position of S

`define MASK_W      4   // Byte lanes on the data bus
`define PIPE_DEPTH  3   // Stages after Decode

`endif

// File: hdl/condUnit.sv
`timescale 1ns/1ps

module condUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stall,
  input  armCtrlPkg::condT  cond,
  input  armCtrlPkg::flagsT aluFlags,
  input  logic [1:0]        flagWrite,  // [1] NZ, [0] CV
  output logic              condEx,
  output armCtrlPkg::flagsT flags
);

  logic ge;                             // Signed greater or equal

  assign ge = (flags.n == flags.v);

  // ========================================
  // Condition table
  // ========================================

  always_comb begin
    case (cond)
      armCtrlPkg::condEq: condEx = flags.z;
      armCtrlPkg::condNe: condEx = !flags.z;
      armCtrlPkg::condCs: condEx = flags.c;
      armCtrlPkg::condCc: condEx = !flags.c;
      armCtrlPkg::condMi: condEx = flags.n;
      armCtrlPkg::condPl: condEx = !flags.n;
      armCtrlPkg::condVs: condEx = flags.v;
      armCtrlPkg::condVc: condEx = !flags.v;
      armCtrlPkg::condHi: condEx = flags.c && !flags.z;
      armCtrlPkg::condLs: condEx = !flags.c || flags.z;
      armCtrlPkg::condGe: condEx = ge;
      armCtrlPkg::condLt: condEx = !ge;
      armCtrlPkg::condGt: condEx = !flags.z && ge;
      armCtrlPkg::condLe: condEx = flags.z || !ge;
      armCtrlPkg::condAl: condEx = 1'b1;
      default:            condEx = 1'b0;  // NV never executes
    endcase
  end

  // ========================================
  // NZCV register
  // ========================================

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (condEx && !stall) begin
      if (flagWrite[1]) begin
        flags.n <= aluFlags.n;
        flags.z <= aluFlags.z;
      end
      if (flagWrite[0]) begin           // Arithmetic only
        flags.c <= aluFlags.c;
        flags.v <= aluFlags.v;
      end
    end
  end

  // Held flags must survive a stalled edge
  assert property (@(posedge clk) disable iff (!rstN) stall |=> $stable(flags))
    else $error("condUnit: flags changed during stall");

endmodule

// File: hdl/ctrlPipeline.sv
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module ctrlPipeline (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   stall,
  input  logic                   flushE,
  input  logic [`INSTR_W-1:0]    instrD,
  input  armCtrlPkg::decodeCtrlT dec,
  input  armCtrlPkg::memDecodeT  mem,
  input  armCtrlPkg::flagsT      aluFlagsE,
  input  logic [1:0]             aluAddrE,   // Low address bits from the ALU
  output armCtrlPkg::exCtrlT     exCtrlE,
  output armCtrlPkg::memCtrlT    memCtrlM,
  output armCtrlPkg::wbCtrlT     wbCtrlW,
  output armCtrlPkg::flagsT      flags
);

  armCtrlPkg::decodeCtrlT decE;
  armCtrlPkg::memDecodeT  memE;
  armCtrlPkg::condT       condE;
  logic                   condEx;
  logic [`MASK_W-1:0]     byteMaskE;
  armCtrlPkg::memCtrlT    memCtrlE;
  armCtrlPkg::wbCtrlT     wbCtrlE;
  armCtrlPkg::wbCtrlT     wbCtrlM;

  // ========================================
  // Decode to Execute
  // ========================================

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decE  <= '0;
      memE  <= '0;
      condE <= armCtrlPkg::condEq;
    end else if (!stall) begin
      if (flushE) begin                 // Bubble, all enables low
        decE  <= '0;
        memE  <= '0;
        condE <= armCtrlPkg::condEq;
      end else begin
        decE  <= dec;
        memE  <= mem;
        condE <= armCtrlPkg::condT'(instrD[`COND_MSB:`COND_LSB]);
      end
    end
  end

  condUnit i_condUnit (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .cond      (condE),
    .aluFlags  (aluFlagsE),
    .flagWrite (decE.flagWrite),
    .condEx    (condEx),
    .flags     (flags)
  );

  // Lane select from the low address bits
  always_comb begin
    byteMaskE = '0;
    if (memE.memAccess) begin
      case (memE.size)
        armCtrlPkg::sizeHalf: byteMaskE = aluAddrE[1] ? 4'b1100 : 4'b0011;
        armCtrlPkg::sizeByte: byteMaskE = {{(`MASK_W-1){1'b0}}, 1'b1} << aluAddrE;
        default:              byteMaskE = '1;  // Whole word
      endcase
    end
  end

  // Condition gating of every write enable
  always_comb begin
    exCtrlE.aluControl  = decE.aluOp;
    exCtrlE.aluSrc      = decE.aluSrc;
    exCtrlE.branchTaken = decE.branch && condEx;

    memCtrlE.memWrite   = memE.memAccess && memE.store && condEx;
    memCtrlE.memtoReg   = memE.memAccess && !memE.store;  // Result mux select
    memCtrlE.byteMask   = byteMaskE;
    memCtrlE.size       = memE.size;
    memCtrlE.signedLoad = memE.signedLoad;

    wbCtrlE.regWrite    = decE.regWrite && condEx;
    wbCtrlE.memtoReg    = memCtrlE.memtoReg;
    wbCtrlE.pcSrc       = decE.pcWrite && condEx;
    wbCtrlE.size        = memE.size;
    wbCtrlE.signedLoad  = memE.signedLoad;
  end

  // ========================================
  // Memory and Writeback
  // ========================================

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memCtrlM <= '0;
      wbCtrlM  <= '0;
      wbCtrlW  <= '0;
    end else if (!stall) begin
      memCtrlM <= memCtrlE;
      wbCtrlM  <= wbCtrlE;              // Carried for Writeback
      wbCtrlW  <= wbCtrlM;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    !(memCtrlM.memWrite && memCtrlM.memtoReg))
    else $error("ctrlPipeline: store and load at once in Memory");

  // Writeback is a bubble right after reset
  assert property (@(posedge clk) !rstN |=> (wbCtrlW == '0))
    else $error("ctrlPipeline: Writeback not cleared by reset");

endmodule

// File: hdl/instrDecoder.sv
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module instrDecoder (
  input  logic [`INSTR_W-1:0]    instrD,
  output armCtrlPkg::decodeCtrlT dec
);

  armCtrlPkg::instrClassT instrClass;
  armCtrlPkg::aluOpT      opcode;
  logic                   sBit;
  logic                   isCompare;    // TST TEQ CMP CMN
  logic                   isArith;      // Opcodes that produce C and V
  logic                   isMsrSpace;   // Compare group without S is MSR/MRS
  logic                   isMult;
  logic                   rdIsPc;

  assign opcode     = armCtrlPkg::aluOpT'(instrD[`OPC_MSB:`OPC_LSB]);
  assign sBit       = instrD[`S_BIT];
  assign isCompare  = (instrD[`OPC_MSB:`OPC_MSB-1] == 2'b10);
  assign isMsrSpace = isCompare && !sBit;
  assign isMult     = (instrD[27:22] == 6'b000000) && (instrD[7:4] == 4'b1001); // MUL, MLA
  assign rdIsPc     = (instrD[`RD_MSB:`RD_LSB] == 4'hF);

  always_comb begin
    case (opcode)
      armCtrlPkg::opSub, armCtrlPkg::opRsb, armCtrlPkg::opAdd, armCtrlPkg::opAdc,
      armCtrlPkg::opSbc, armCtrlPkg::opRsc, armCtrlPkg::opCmp, armCtrlPkg::opCmn:
        isArith = 1'b1;
      default:
        isArith = 1'b0;                 // Logical group keeps C and V
    endcase
  end

  // ========================================
  // Classification
  // ========================================

  always_comb begin
    instrClass = armCtrlPkg::nop;       // SWI, undefined, LDM/STM, coprocessor
    if (armCtrlPkg::isWordXfer(instrD))
      instrClass = armCtrlPkg::ldrStr;
    else if (armCtrlPkg::isHalfXfer(instrD))
      instrClass = armCtrlPkg::ldrStrHalf;
    else if (instrD[27:25] == 3'b101)
      instrClass = armCtrlPkg::branch;
    else if (isMult)
      instrClass = armCtrlPkg::mult;
    else if ((instrD[27:25] == 3'b001) && !isMsrSpace)
      instrClass = armCtrlPkg::dpImm;
    else if ((instrD[27:25] == 3'b000) && !instrD[4] && !isMsrSpace)
      instrClass = armCtrlPkg::dpReg;   // Immediate shift only
  end

  // ========================================
  // Control word
  // ========================================

  always_comb begin
    dec            = '0;
    dec.instrClass = instrClass;
    dec.aluOp      = armCtrlPkg::opAdd; // Address and branch target adds
    case (instrClass)
      armCtrlPkg::dpImm, armCtrlPkg::dpReg: begin
        dec.aluOp     = opcode;
        dec.aluSrc    = (instrClass == armCtrlPkg::dpImm);
        dec.regWrite  = !isCompare;
        dec.flagWrite = {sBit, sBit && isArith};
        dec.pcWrite   = !isCompare && rdIsPc;
      end
      armCtrlPkg::mult: begin
        dec.regWrite  = 1'b1;
        dec.flagWrite = {sBit, 1'b0};   // NZ only
      end
      armCtrlPkg::ldrStr, armCtrlPkg::ldrStrHalf: begin
        dec.aluOp    = instrD[`U_BIT] ? armCtrlPkg::opAdd : armCtrlPkg::opSub;
        dec.aluSrc   = (instrClass == armCtrlPkg::ldrStr) ? !instrD[`I_BIT]
                                                          : instrD[`HIMM_BIT];
        dec.regWrite = instrD[`L_BIT];  // Loads write Rd
        dec.pcWrite  = instrD[`L_BIT] && rdIsPc;
      end
      armCtrlPkg::branch: begin
        dec.aluSrc  = 1'b1;             // PC plus offset
        dec.branch  = 1'b1;
        dec.pcWrite = 1'b1;
      end
      default: ;                        // Nop keeps the cleared word
    endcase
  end

endmodule

// File: hdl/memAccessDecoder.sv
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module memAccessDecoder (
  input  logic [`INSTR_W-1:0]   instrD,
  output armCtrlPkg::memDecodeT mem
);

  logic       wordXfer;
  logic       halfXfer;
  logic       load;
  logic [1:0] sh;                     // Halfword type bits

  assign wordXfer = armCtrlPkg::isWordXfer(instrD);
  assign halfXfer = armCtrlPkg::isHalfXfer(instrD);
  assign load     = instrD[`L_BIT];
  assign sh       = instrD[6:5];

  always_comb begin
    mem = '0;                         // Not a memory instruction
    if (wordXfer) begin
      mem.memAccess = 1'b1;
      mem.store     = !load;
      mem.size      = instrD[`B_BIT] ? armCtrlPkg::sizeByte : armCtrlPkg::sizeWord;
    end else if (halfXfer) begin
      mem.memAccess = 1'b1;
      mem.store     = !load;          // Only STRH reaches here as a store
      // SH 10 is LDRSB, 01 and 11 move halfwords
      mem.size = (sh == 2'b10) ? armCtrlPkg::sizeByte : armCtrlPkg::sizeHalf;
      mem.signedLoad = {sh == 2'b10, sh == 2'b11};
    end
  end

endmodule

// File: sim/armControllerTb.sv
`timescale 1ns/1ps
`include "armCtrl_params.svh"

module armControllerTb;

  localparam logic [2:0] kindDp     = 3'd0;
  localparam logic [2:0] kindMul    = 3'd1;
  localparam logic [2:0] kindWord   = 3'd2;   // LDR/STR word and byte
  localparam logic [2:0] kindHalf   = 3'd3;   // STRH LDRH LDRSB LDRSH
  localparam logic [2:0] kindBranch = 3'd4;
  localparam logic [2:0] kindNop    = 3'd5;   // SWI

  logic                   clk;
  logic                   rstN;
  logic                   stall;
  logic                   flushE;
  logic [`INSTR_W-1:0]    instrD;
  armCtrlPkg::flagsT      aluFlagsE;
  logic [1:0]             aluAddrE;
  armCtrlPkg::exCtrlT     exCtrlE;
  armCtrlPkg::memCtrlT    memCtrlM;
  armCtrlPkg::wbCtrlT     wbCtrlW;
  armCtrlPkg::flagsT      flags;

  // ========================================
  // Reference model state
  // ========================================

  armCtrlPkg::decodeCtrlT expDec;             // Decode of the word on instrD
  armCtrlPkg::memDecodeT  expMem;
  armCtrlPkg::decodeCtrlT decE;               // Model Execute register
  armCtrlPkg::memDecodeT  memE;
  armCtrlPkg::condT       condE;
  logic                   passE;              // Condition met in Execute
  armCtrlPkg::exCtrlT     expEx;
  armCtrlPkg::memCtrlT    expMemE;
  armCtrlPkg::memCtrlT    expMemM;
  armCtrlPkg::wbCtrlT     expWbE;
  armCtrlPkg::wbCtrlT     expWbM;
  armCtrlPkg::wbCtrlT     expWbW;
  armCtrlPkg::flagsT      expFlags;

  integer                 seed;
  int                     errors;
  int                     cycles;
  string                  testName;
  logic [31:0]            pick;

  clkGen #(.period(100), .resetCycles(2)) i_clkGen (.clk(clk), .rstN(rstN));

  armController i_armController (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .flushE    (flushE),
    .instrD    (instrD),
    .aluFlagsE (aluFlagsE),
    .aluAddrE  (aluAddrE),
    .exCtrlE   (exCtrlE),
    .memCtrlM  (memCtrlM),
    .wbCtrlW   (wbCtrlW),
    .flags     (flags)
  );

  // ARM conditions come in pairs, the odd code inverts the even one
  function automatic logic condHolds(input logic [3:0] cond, input armCtrlPkg::flagsT f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;                    // EQ
      3'd1:    base = f.c;                    // CS
      3'd2:    base = f.n;                    // MI
      3'd3:    base = f.v;                    // VS
      3'd4:    base = f.c && !f.z;            // HI
      3'd5:    base = (f.n == f.v);           // GE
      3'd6:    base = !f.z && (f.n == f.v);   // GT
      default: base = 1'b1;                   // AL, so NV never runs
    endcase
    return base ^ cond[0];
  endfunction

  function automatic logic [3:0] laneMask(input armCtrlPkg::memDecodeT m, input logic [1:0] addr);
    if (!m.memAccess)
      return 4'b0000;
    case (m.size)
      armCtrlPkg::sizeByte: return 4'b0001 << addr;
      armCtrlPkg::sizeHalf: return addr[1] ? 4'b1100 : 4'b0011;
      default:              return 4'b1111;
    endcase
  endfunction

  // Encode one instruction of a kind and state its expected Decode outputs
  task automatic build(input logic [2:0] kind, input logic [31:0] r, input logic [3:0] cond,
                       output logic [31:0] instr, output armCtrlPkg::decodeCtrlT d,
                       output armCtrlPkg::memDecodeT m);
    logic [3:0] opc;
    logic [3:0] rd;
    logic [1:0] sh;
    logic       cmp;
    logic       sBit;
    logic       halfLoad;
    opc      = r[4:1];
    rd       = r[8:5];
    cmp      = (opc[3:2] == 2'b10);           // TST TEQ CMP CMN
    sBit     = r[9] || cmp;                   // A compare always sets flags
    sh       = (r[1:0] == 2'b00) ? 2'b01 : r[1:0];
    halfLoad = (r[1:0] != 2'b00);
    d        = '0;
    m        = '0;
    d.aluOp  = armCtrlPkg::opAdd;
    case (kind)
      kindDp: begin                           // Register form keeps bit 4 clear
        instr = {cond, 2'b00, r[0], opc, sBit, r[13:10], rd,
                 r[0] ? r[25:14] : {r[20:14], 1'b0, r[24:21]}};
        d.instrClass = r[0] ? armCtrlPkg::dpImm : armCtrlPkg::dpReg;
        d.aluOp      = armCtrlPkg::aluOpT'(opc);
        d.aluSrc     = r[0];
        d.regWrite   = !cmp;
        d.flagWrite  = {sBit, sBit && ((opc >= 4'd2 && opc <= 4'd7) ||
                                       opc == 4'd10 || opc == 4'd11)};
        d.pcWrite    = !cmp && (rd == 4'hF);
      end
      kindMul: begin
        instr = {cond, 6'b000000, r[0], r[9], rd, r[15:12], r[19:16], 4'b1001, r[23:20]};
        d.instrClass = armCtrlPkg::mult;
        d.regWrite   = 1'b1;
        d.flagWrite  = {r[9], 1'b0};          // Never C and V
      end
      kindWord: begin                         // I r[0], U r[10], B r[11], L r[3]
        instr = {cond, 2'b01, r[0], 1'b1, r[10], r[11], 1'b0, r[3], r[15:12], rd,
                 r[0] ? {r[22:16], 1'b0, r[26:23]} : r[27:16]};
        d.instrClass = armCtrlPkg::ldrStr;
        d.aluOp      = r[10] ? armCtrlPkg::opAdd : armCtrlPkg::opSub;
        d.aluSrc     = !r[0];
        d.regWrite   = r[3];
        d.pcWrite    = r[3] && (rd == 4'hF);
        m.memAccess  = 1'b1;
        m.store      = !r[3];
        m.size       = r[11] ? armCtrlPkg::sizeByte : armCtrlPkg::sizeWord;
      end
      kindHalf: begin
        instr = {cond, 3'b000, 1'b1, r[10], r[11], 1'b0, halfLoad, r[15:12], rd,
                 r[19:16], 1'b1, sh, 1'b1, r[23:20]};
        d.instrClass = armCtrlPkg::ldrStrHalf;
        d.aluOp      = r[10] ? armCtrlPkg::opAdd : armCtrlPkg::opSub;
        d.aluSrc     = r[11];                 // Immediate offset
        d.regWrite   = halfLoad;
        d.pcWrite    = halfLoad && (rd == 4'hF);
        m.memAccess  = 1'b1;
        m.store      = !halfLoad;
        m.size       = (sh == 2'b10) ? armCtrlPkg::sizeByte : armCtrlPkg::sizeHalf;
        m.signedLoad = {sh == 2'b10, sh == 2'b11};
      end
      kindBranch: begin
        instr = {cond, 3'b101, 1'b0, r[23:0]};
        d.instrClass = armCtrlPkg::branch;
        d.aluSrc     = 1'b1;
        d.branch     = 1'b1;
        d.pcWrite    = 1'b1;
      end
      default: begin
        instr = {cond, 4'hF, r[23:0]};
        d.instrClass = armCtrlPkg::nop;
      end
    endcase
  endtask

  // ========================================
  // Expected stages
  // ========================================

  always_comb begin
    passE               = condHolds(condE, expFlags);
    expEx.aluControl    = decE.aluOp;
    expEx.aluSrc        = decE.aluSrc;
    expEx.branchTaken   = decE.branch && passE;
    expMemE.memWrite    = memE.memAccess && memE.store && passE;
    expMemE.memtoReg    = memE.memAccess && !memE.store;
    expMemE.byteMask    = laneMask(memE, aluAddrE);
    expMemE.size        = memE.size;
    expMemE.signedLoad  = memE.signedLoad;
    expWbE.regWrite     = decE.regWrite && passE;
    expWbE.memtoReg     = expMemE.memtoReg;
    expWbE.pcSrc        = decE.pcWrite && passE;
    expWbE.size         = memE.size;
    expWbE.signedLoad   = memE.signedLoad;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      decE     <= '0;
      memE     <= '0;
      condE    <= armCtrlPkg::condEq;
      expMemM  <= '0;
      expWbM   <= '0;
      expWbW   <= '0;
      expFlags <= '0;
    end else if (!stall) begin
      if (flushE) begin                       // Bubble has no enables
        decE <= '0;
        memE <= '0;
      end else begin
        decE <= expDec;
        memE <= expMem;
      end
      condE   <= armCtrlPkg::condT'(instrD[`COND_MSB:`COND_LSB]);
      expMemM <= expMemE;
      expWbM  <= expWbE;
      expWbW  <= expWbM;
      if (passE && decE.flagWrite[1]) begin
        expFlags.n <= aluFlagsE.n;
        expFlags.z <= aluFlagsE.z;
      end
      if (passE && decE.flagWrite[0]) begin   // Logical ops keep C and V
        expFlags.c <= aluFlagsE.c;
        expFlags.v <= aluFlagsE.v;
      end
    end
  end

  always @(posedge clk) if (rstN) cycles++;

  // ========================================
  // Checks
  // ========================================

  task automatic logMismatch(input string what, input logic [31:0] expV,
                             input logic [31:0] actV);
    errors++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", testName, what, expV, actV);
  endtask

  assert property (@(posedge clk) !rstN |=> (!exCtrlE.branchTaken && memCtrlM == '0 &&
                                             wbCtrlW == '0 && flags == '0))
    else logMismatch("reset", 32'h0, 32'({$sampled(exCtrlE.branchTaken), $sampled(memCtrlM),
                                         $sampled(wbCtrlW), $sampled(flags)}));

  assert property (@(posedge clk) disable iff (!rstN) i_armController.dec == expDec)
    else logMismatch("decode", 32'($sampled(expDec)), 32'($sampled(i_armController.dec)));

  assert property (@(posedge clk) disable iff (!rstN) i_armController.mem == expMem)
    else logMismatch("memDecode", 32'($sampled(expMem)), 32'($sampled(i_armController.mem)));

  assert property (@(posedge clk) disable iff (!rstN) exCtrlE == expEx)
    else logMismatch("exCtrlE", 32'($sampled(expEx)), 32'($sampled(exCtrlE)));

  assert property (@(posedge clk) disable iff (!rstN) memCtrlM == expMemM)
    else logMismatch("memCtrlM", 32'($sampled(expMemM)), 32'($sampled(memCtrlM)));

  assert property (@(posedge clk) disable iff (!rstN) wbCtrlW == expWbW)
    else logMismatch("wbCtrlW", 32'($sampled(expWbW)), 32'($sampled(wbCtrlW)));

  assert property (@(posedge clk) disable iff (!rstN) flags == expFlags)
    else logMismatch("flags", 32'($sampled(expFlags)), 32'($sampled(flags)));

  // Everything freezes for one cycle per stall
  assert property (@(posedge clk) disable iff (!rstN)
    stall |=> ($stable(exCtrlE) && $stable(memCtrlM) && $stable(wbCtrlW) && $stable(flags)))
    else begin
      errors++;
      $display("Outputs moved during a stall in %s", testName);
    end

  // ========================================
  // Stimulus
  // ========================================

  task automatic present(input logic [2:0] kind, input logic [3:0] cond,
                         input logic holdPipe, input logic bubble);
    logic [31:0]            r;
    logic [31:0]            side;
    logic [31:0]            instr;
    armCtrlPkg::decodeCtrlT d;
    armCtrlPkg::memDecodeT  m;
    r    = $random(seed);
    side = $random(seed);
    build(kind, r, cond, instr, d, m);
    @(negedge clk);
    instrD    = instr;
    expDec    = d;
    expMem    = m;
    stall     = holdPipe;
    flushE    = bubble;
    aluFlagsE = side[3:0];
    aluAddrE  = side[5:4];                    // All four lanes over a run
  endtask

  // No-ops until Writeback is empty, bounded
  task automatic drain();
    int i;
    for (i = 0; i < `PIPE_DEPTH + 4; i++) begin
      present(kindNop, 4'hE, 1'b0, 1'b0);
      if (i >= `PIPE_DEPTH && wbCtrlW == '0 && memCtrlM == '0)
        break;
    end
    if (wbCtrlW != '0 || memCtrlM != '0) begin
      errors++;
      $display("Pipeline did not empty after %s", testName);
    end
  endtask

  initial begin
    int t;
    seed      = 59;
    errors    = 0;
    cycles    = 0;
    stall     = 1'b0;
    flushE    = 1'b0;
    aluFlagsE = '0;
    aluAddrE  = '0;
    build(kindNop, 32'h0, 4'hE, instrD, expDec, expMem);
    testName  = "reset";
    for (t = 0; t < 10 && !rstN; t++)
      @(negedge clk);
    if (!rstN) begin
      errors++;
      $display("Reset was never released");
    end

    testName = "dataProc";
    repeat (48) present(kindDp, 4'hE, 1'b0, 1'b0);
    testName = "multiply";
    repeat (12) present(kindMul, 4'hE, 1'b0, 1'b0);
    drain();

    testName = "condExec";                    // Random codes, NV included
    repeat (64) begin
      pick = $random(seed);
      present(pick[2:0] % 3'd6, pick[7:4], 1'b0, 1'b0);
    end
    drain();

    testName = "loadStore";
    repeat (96) begin
      pick = $random(seed);
      present(pick[0] ? kindWord : kindHalf, 4'hE, 1'b0, 1'b0);
    end
    testName = "branch";
    repeat (16) begin
      pick = $random(seed);
      present(kindBranch, pick[0] ? 4'hE : pick[7:4], 1'b0, 1'b0);
    end
    drain();

    testName = "stallFlush";                  // About a quarter each
    repeat (96) begin
      pick = $random(seed);
      present(pick[2:0] % 3'd6, pick[7:4], pick[9:8] == 2'b00, pick[11:10] == 2'b00);
    end
    drain();

    $display("Checked %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Backstop far beyond the run length
  initial begin
    #1_000_000;
    $display("Run exceeded its time limit");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: sim/clkGen.sv
`timescale 1ns/1ps

module clkGen #(
  parameter int period      = 100,  // ns
  parameter int resetCycles = 2     // Rising edges seen with reset low
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule
